/* Bender.yml */
package:
  name: conv_accum

sources:
  - source/conv_accum_pkg.sv
  - source/channel_sequencer.sv
  - source/partial_sum_buffer.sv
  - source/channel_adder.sv
  - source/result_credit_stage.sv
  - source/conv_accum_top.sv
  - target: test
    files:
      - tb/conv_accum_checker.sv
      - tb/conv_accum_tb.sv

/* conv_accum_top.f */
source/conv_accum_pkg.sv
source/channel_sequencer.sv
source/partial_sum_buffer.sv
source/channel_adder.sv
source/result_credit_stage.sv
source/conv_accum_top.sv
tb/conv_accum_checker.sv
tb/conv_accum_tb.sv

/* source/channel_adder.sv */
module channel_adder
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE = 256
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  acc_req_t             req,
  input  pxl_t                 rd_data,
  input  logic                 res_full,
  output logic                 stall,
  output logic                 rd_en,
  output logic [IDX_WIDTH-1:0] rd_addr,
  output logic                 wr_en,
  output logic [IDX_WIDTH-1:0] wr_addr,
  output pxl_t                 wr_data,
  output logic                 res_valid,
  output out_beat_t            res
);

  logic                 accept;
  logic                 s1_valid;
  acc_req_t             s1_req;
  pxl_t                 sum;
  logic                 s2_valid;
  acc_op_t              s2_op;
  logic [IDX_WIDTH-1:0] s2_idx;
  pxl_t                 s2_sum;
  logic                 s2_emit;

  assign s2_emit   = (s2_op == OP_LAST) || (s2_op == OP_SINGLE);
  assign res_valid = s2_valid && s2_emit;

  // Freeze the whole pipe while a result waits on a full output FIFO
  assign stall  = res_valid && res_full;
  assign accept = req_valid && !stall;

  // Only mid and last channels need the stored sum
  assign rd_en   = accept && ((req.op == OP_MID) || (req.op == OP_LAST));
  assign rd_addr = req.idx;

  //////////////////////////////
  // Stage 1, buffer read
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      s1_req <= req;
    end
  end

  // First channel adds zero
  always_comb begin
    if ((s1_req.op == OP_FIRST) || (s1_req.op == OP_SINGLE)) begin
      sum = s1_req.pxl;
    end else begin
      sum = s1_req.pxl + rd_data;
    end
  end

  //////////////////////////////
  // Stage 2, write-back or emit
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else if (!stall) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      s2_op  <= s1_req.op;
      s2_idx <= s1_req.idx;
      s2_sum <= sum;
    end
  end

  assign wr_en   = s2_valid && !s2_emit;
  assign wr_addr = s2_idx;
  assign wr_data = s2_sum;

  assign res.sum  = s2_sum;
  assign res.last = (s2_idx == IDX_WIDTH'(IMAGE_SIZE - 1));

endmodule

/* source/channel_sequencer.sv */
module channel_sequencer
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE  = 256,
  parameter int CHANNEL_NUM = 512
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  input  in_beat_t in_beat,
  input  logic     stall,
  output logic     in_credit,
  output logic     req_valid,
  output acc_req_t req
);

  localparam int PTR_W = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
  localparam int CNT_W = $clog2(IN_CREDITS + 1);
  localparam int CH_W  = (CHANNEL_NUM > 1) ? $clog2(CHANNEL_NUM) : 1;

  in_beat_t             fifo_mem [IN_CREDITS];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     fifo_cnt;
  logic                 fifo_full;
  logic                 push;
  logic                 pop;
  logic [IDX_WIDTH-1:0] pix_cnt;
  logic [CH_W-1:0]      ch_cnt;
  acc_op_t              op;

  //////////////////////////////
  // Input credit FIFO
  //////////////////////////////

  assign fifo_full = (fifo_cnt == CNT_W'(IN_CREDITS));
  assign push      = in_valid && !fifo_full;
  assign req_valid = (fifo_cnt != '0);
  assign pop       = req_valid && !stall;

  // One credit back upstream per popped beat
  assign in_credit = pop;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= in_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(pop);
    end
  end

  //////////////////////////////
  // Pixel and channel counters
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt <= '0;
      ch_cnt  <= '0;
    end else if (pop) begin
      if (pix_cnt == IDX_WIDTH'(IMAGE_SIZE - 1)) begin
        pix_cnt <= '0;
        ch_cnt  <= (ch_cnt == CH_W'(CHANNEL_NUM - 1)) ? '0 : ch_cnt + 1'b1;
      end else begin
        pix_cnt <= pix_cnt + 1'b1;
      end
    end
  end

  // Decode the channel position into an accumulate op
  always_comb begin
    if (CHANNEL_NUM == 1) begin
      op = OP_SINGLE;
    end else if (ch_cnt == '0) begin
      op = OP_FIRST;
    end else if (ch_cnt == CH_W'(CHANNEL_NUM - 1)) begin
      op = OP_LAST;
    end else begin
      op = OP_MID;
    end
  end

  // Head of FIFO, held steady while stalled
  assign req.op  = op;
  assign req.idx = pix_cnt;
  assign req.pxl = fifo_mem[rd_ptr].data;

endmodule

/* source/conv_accum_pkg.sv */
package conv_accum_pkg;

  //////////////////////////////
  // Data widths
  //////////////////////////////

  localparam int PXL_WIDTH = 32;

  // Pixel index, sized for the largest supported image
  localparam int IDX_WIDTH = 16;

  //////////////////////////////
  // Credit depths
  //////////////////////////////

  // Input FIFO depth, also the upstream's starting credits
  localparam int IN_CREDITS = 4;

  // Credits held by the output stage after reset
  localparam int OUT_CREDITS = 4;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic signed [PXL_WIDTH-1:0] pxl_t;

  // Channel and position are implied by arrival order
  typedef struct packed {
    pxl_t data;
  } in_beat_t;

  typedef enum logic [1:0] {
    OP_FIRST  = 2'd0,  // store the pixel
    OP_MID    = 2'd1,  // add and store
    OP_LAST   = 2'd2,  // add and emit
    OP_SINGLE = 2'd3   // emit as is, single-channel layer
  } acc_op_t;

  typedef struct packed {
    acc_op_t              op;
    logic [IDX_WIDTH-1:0] idx;
    pxl_t                 pxl;
  } acc_req_t;

  typedef struct packed {
    pxl_t sum;
    logic last;
  } out_beat_t;

endpackage

/* source/conv_accum_top.sv */
module conv_accum_top
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE  = 256,
  parameter int CHANNEL_NUM = 512
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      in_valid,
  input  in_beat_t  in_beat,
  input  logic      out_credit,
  output logic      in_credit,
  output logic      out_valid,
  output out_beat_t out_beat
);

  logic                 req_valid;
  acc_req_t             req;
  logic                 stall;
  logic                 rd_en;
  logic [IDX_WIDTH-1:0] rd_addr;
  pxl_t                 rd_data;
  logic                 wr_en;
  logic [IDX_WIDTH-1:0] wr_addr;
  pxl_t                 wr_data;
  logic                 res_valid;
  out_beat_t            res;
  logic                 res_full;

  // Decode
  channel_sequencer #(
    .IMAGE_SIZE (IMAGE_SIZE),
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_channel_sequencer (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_beat  (in_beat),
    .stall    (stall),
    .in_credit(in_credit),
    .req_valid(req_valid),
    .req      (req)
  );

  partial_sum_buffer #(
    .IMAGE_SIZE(IMAGE_SIZE)
  ) u_partial_sum_buffer (
    .clk    (clk),
    .rd_en  (rd_en),
    .rd_addr(rd_addr),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_data(rd_data)
  );

  // Execute
  channel_adder #(
    .IMAGE_SIZE(IMAGE_SIZE)
  ) u_channel_adder (
    .clk      (clk),
    .reset    (reset),
    .req_valid(req_valid),
    .req      (req),
    .rd_data  (rd_data),
    .res_full (res_full),
    .stall    (stall),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .res_valid(res_valid),
    .res      (res)
  );

  // Result
  result_credit_stage u_result_credit_stage (
    .clk       (clk),
    .reset     (reset),
    .res_valid (res_valid),
    .res       (res),
    .out_credit(out_credit),
    .res_full  (res_full),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

endmodule

/* source/partial_sum_buffer.sv */
module partial_sum_buffer
  import conv_accum_pkg::*;
#(
  parameter int IMAGE_SIZE = 256
) (
  input  logic                 clk,
  input  logic                 rd_en,
  input  logic [IDX_WIDTH-1:0] rd_addr,
  input  logic                 wr_en,
  input  logic [IDX_WIDTH-1:0] wr_addr,
  input  pxl_t                 wr_data,
  output pxl_t                 rd_data
);

  localparam int AW = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1;

  // One running sum per pixel position
  pxl_t mem [IMAGE_SIZE];

  logic [AW-1:0] rd_idx;
  logic [AW-1:0] wr_idx;

  assign rd_idx = rd_addr[AW-1:0];
  assign wr_idx = wr_addr[AW-1:0];

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  //////////////////////////////
  // Registered read port
  //////////////////////////////

  // Data holds while rd_en is low, so a stalled reader keeps its operand
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_idx];
    end
  end

endmodule

/* source/result_credit_stage.sv */
module result_credit_stage
  import conv_accum_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      res_valid,
  input  out_beat_t res,
  input  logic      out_credit,
  output logic      res_full,
  output logic      out_valid,
  output out_beat_t out_beat
);

  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);
  localparam int CRD_W      = $clog2(OUT_CREDITS + 1);

  out_beat_t        fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  logic [CRD_W-1:0] credit_cnt;
  logic             push;

  //////////////////////////////
  // Output FIFO
  //////////////////////////////

  assign res_full = (fifo_cnt == CNT_W'(FIFO_DEPTH));
  assign push     = res_valid && !res_full;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= res;
    end
  end

  // Send whenever a beat is queued and a credit is held
  assign out_valid = (fifo_cnt != '0) && (credit_cnt != '0);
  assign out_beat  = fifo_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (out_valid) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(out_valid);
    end
  end

  //////////////////////////////
  // Downstream credits
  //////////////////////////////

  // Spend and return in one cycle cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_cnt <= CRD_W'(OUT_CREDITS);
    end else begin
      credit_cnt <= credit_cnt - CRD_W'(out_valid) + CRD_W'(out_credit);
    end
  end

endmodule

/* tb/conv_accum_checker.sv */
module conv_accum_checker
  import conv_accum_pkg::*;
(
  input logic                               clk,
  input logic                               reset,
  input logic                               in_valid,
  input logic                               in_fifo_full,
  input logic                               out_valid,
  input logic                               out_credit,
  input logic [$clog2(OUT_CREDITS + 1)-1:0] credit_cnt
);

  // Raised by any failing assertion below
  logic assert_failed = 1'b0;

  // Downstream credits as seen at the ports
  int credits_held;

  always_ff @(posedge clk) begin
    if (reset) begin
      credits_held <= OUT_CREDITS;
    end else begin
      credits_held <= credits_held - (out_valid ? 1 : 0) + (out_credit ? 1 : 0);
    end
  end

  // Upstream must hold a credit, so the FIFO always has room
  a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    in_valid |-> !in_fifo_full)
    else begin
      $error("Input FIFO offered a beat while full");
      assert_failed = 1'b1;
    end

  a_send_needs_credit: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> (credits_held > 0))
    else begin
      $error("out_valid high with no downstream credit");
      assert_failed = 1'b1;
    end

  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    credit_cnt <= OUT_CREDITS)
    else begin
      $error("Downstream credit count above its initial value");
      assert_failed = 1'b1;
    end

  a_idle_after_reset: assert property (@(posedge clk)
    reset |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      assert_failed = 1'b1;
    end

endmodule

bind conv_accum_top conv_accum_checker u_conv_accum_checker (
  .clk         (clk),
  .reset       (reset),
  .in_valid    (in_valid),
  .in_fifo_full(u_channel_sequencer.fifo_full),
  .out_valid   (out_valid),
  .out_credit  (out_credit),
  .credit_cnt  (u_result_credit_stage.credit_cnt)
);

/* tb/conv_accum_tb.sv */
module conv_accum_tb
  import conv_accum_pkg::*;
;

  localparam int IMAGE_SIZE  = 16;
  localparam int CHANNEL_NUM = 3;
  localparam int unsigned SEED = 32'ha542b275;

  // Layers per test, in run order
  localparam int L_DIRECTED = 1;
  localparam int L_RANDOM   = 1;
  localparam int L_B2B      = 3;
  localparam int L_BACKPR   = 2;
  localparam int L_GAPS     = 2;

  localparam int TOTAL_LAYERS   = L_DIRECTED + L_RANDOM + L_B2B + L_BACKPR + L_GAPS;
  localparam int TOTAL_BEATS    = TOTAL_LAYERS * IMAGE_SIZE * CHANNEL_NUM;
  localparam int TOTAL_OUTPUTS  = TOTAL_LAYERS * IMAGE_SIZE;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_BEATS;

  logic      clk        = 1'b0;
  logic      reset      = 1'b1;
  logic      in_valid   = 1'b0;
  in_beat_t  in_beat    = '0;
  logic      out_credit = 1'b0;
  logic      in_credit;
  logic      out_valid;
  out_beat_t out_beat;

  // Pixels per layer, channel and position for the reference
  pxl_t img [TOTAL_LAYERS][CHANNEL_NUM][IMAGE_SIZE];

  pxl_t        stim_q [$];
  int          gap_q [$];
  out_beat_t   exp_q [$];
  string       name_q [$];
  int          delay_q [$];
  int          due_q [$];
  int          layer_base = 0;
  int          up_credits = IN_CREDITS;
  int          idle_left  = 0;
  int          sent_cnt   = 0;
  int          pulse_cnt  = 0;
  int          out_total  = 0;
  int          cycle_cnt  = 0;

  conv_accum_top #(
    .IMAGE_SIZE (IMAGE_SIZE),
    .CHANNEL_NUM(CHANNEL_NUM)
  ) u_conv_accum_top (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .out_credit(out_credit),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

  always #4 clk = ~clk;

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_beat(input string name, input out_beat_t exp, input out_beat_t act);
    if (exp !== act) begin
      abort_run($sformatf("[FAIL] %s: expected sum %0d last %0b, actual sum %0d last %0b",
                          name, exp.sum, exp.last, act.sum, act.last));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  //////////////////////////////
  // Reference and stimulus
  //////////////////////////////

  // Wrapping sum of one position over all channels
  function automatic out_beat_t expected_beat(input int layer, input int pos);
    out_beat_t beat;
    pxl_t      acc;
    acc = '0;
    for (int c = 0; c < CHANNEL_NUM; c++) begin
      acc = acc + img[layer][c][pos];
    end
    beat.sum  = acc;
    beat.last = (pos == IMAGE_SIZE - 1);
    return beat;
  endfunction

  task automatic add_test(input string name, input int layers, input bit directed,
                          input int gap_max, input int delay_max);
    pxl_t v;
    for (int l = 0; l < layers; l++) begin
      for (int c = 0; c < CHANNEL_NUM; c++) begin
        for (int p = 0; p < IMAGE_SIZE; p++) begin
          if (directed) begin
            v = pxl_t'(100 * c + p);
          end else if (p == 0) begin
            // Large positives, the sum overflows
            v = pxl_t'(32'h7fff_fff0 + c);
          end else if (p == 1) begin
            v = pxl_t'(32'h8000_0000 - c);
          end else begin
            v = pxl_t'($urandom());
          end
          img[layer_base + l][c][p] = v;
          stim_q.push_back(v);
          gap_q.push_back($urandom_range(gap_max, 0));
        end
      end
      for (int p = 0; p < IMAGE_SIZE; p++) begin
        exp_q.push_back(expected_beat(layer_base + l, p));
        name_q.push_back(name);
        delay_q.push_back($urandom_range(delay_max, 0));
      end
    end
    layer_base += layers;
  endtask

  //////////////////////////////
  // Upstream source
  //////////////////////////////

  always @(posedge clk) begin : upstream_source
    int       avail;
    in_beat_t nb;
    avail = up_credits + (in_credit ? 1 : 0);
    if (reset) begin
      up_credits <= IN_CREDITS;
      in_valid   <= 1'b0;
      idle_left  <= 0;
    end else begin
      if (in_credit) begin
        pulse_cnt <= pulse_cnt + 1;
      end
      if (idle_left > 0) begin
        in_valid  <= 1'b0;
        idle_left <= idle_left - 1;
      end else if (avail > 0 && stim_q.size() > 0) begin
        nb.data   = stim_q.pop_front();
        in_valid  <= 1'b1;
        in_beat   <= nb;
        idle_left <= gap_q.pop_front();
        sent_cnt  <= sent_cnt + 1;
        avail     = avail - 1;
      end else begin
        in_valid <= 1'b0;
      end
      up_credits <= avail;
    end
  end

  //////////////////////////////
  // Downstream sink
  //////////////////////////////

  // Credits go back in arrival order once their delay has run out
  always @(posedge clk) begin : downstream_sink
    int due;
    if (reset) begin
      out_credit <= 1'b0;
    end else begin
      if (out_valid && delay_q.size() > 0) begin
        due = cycle_cnt + delay_q.pop_front();
        due_q.push_back(due);
      end
      if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
        out_credit <= 1'b1;
        void'(due_q.pop_front());
      end else begin
        out_credit <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin : compare_outputs
    int        need_pops;
    out_beat_t exp_beat;
    if (!reset && out_valid) begin
      // Pops needed before this beat may leave, through its last-channel pixel
      need_pops = (out_total / IMAGE_SIZE) * IMAGE_SIZE * CHANNEL_NUM
                + (CHANNEL_NUM - 1) * IMAGE_SIZE + (out_total % IMAGE_SIZE) + 1;
      if (exp_q.size() == 0) begin
        abort_run("An output beat arrived after all expected beats were checked");
      end else if (pulse_cnt < need_pops) begin
        abort_run("An output beat appeared before its last-channel pixel was taken");
      end else begin
        exp_beat = exp_q.pop_front();
        check_beat(name_q.pop_front(), exp_beat, out_beat);
        out_total <= out_total + 1;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run("The run timed out waiting for outputs");
    end else if (u_conv_accum_top.u_conv_accum_checker.assert_failed) begin
      abort_run("A bound assertion on the DUT failed");
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(SEED));
    add_test("directed_image", L_DIRECTED, 1'b1, 0, 0);
    add_test("random_overflow", L_RANDOM, 1'b0, 0, 0);
    add_test("back_to_back_layers", L_B2B, 1'b0, 0, 0);
    add_test("downstream_backpressure", L_BACKPR, 1'b0, 0, 20);
    add_test("upstream_gaps", L_GAPS, 1'b0, 6, 0);
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    while (out_total < TOTAL_OUTPUTS) begin
      @(posedge clk);
    end
    @(posedge clk);
    check_count("beats_sent", TOTAL_BEATS, sent_cnt);
    check_count("in_credit_pulses", sent_cnt, pulse_cnt);
    if (u_conv_accum_top.u_conv_accum_checker.assert_failed) begin
      abort_run("A bound assertion on the DUT failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule
